/* all.f */
+incdir+src
src/hps_bus_pkg.sv
src/hps_dev_pkg.sv
src/hps_cmd_framer.sv
src/hps_input_regs.sv
src/hps_file_loader.sv
src/ps2_kbd_tx.sv
src/hps_io.sv
verif/hps_io_checker.sv
verif/hps_io_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it from the project root
# the exit status of the simulation is the result of the run
verilator --binary --assert -Wno-fatal -f all.f --top-module hps_io_tb &&
	./obj_dir/Vhps_io_tb ||
	exit 1

/* src/hps_bus_pkg.sv */
`default_nettype none

`include "hps_cfg.svh"

package hps_bus_pkg;

	//////////////////////////////////////////////////
	// host bus words
	//////////////////////////////////////////////////

	typedef logic [`HPS_WORD_W-1:0] hps_word_t;

	// 0 is the command word, arguments follow
	typedef logic [`HPS_IDX_W-1:0] hps_idx_t;

	// command codes sent as word 0 of a window
	typedef enum logic [`HPS_WORD_W-1:0] {
		CMD_CFG      = 16'h0001,
		CMD_JOY0     = 16'h0002,
		CMD_JOY1     = 16'h0003,
		CMD_KBD      = 16'h0005,
		CMD_STATUS   = 16'h001E,
		CMD_STAT_REQ = 16'h0029,
		CMD_FILE_TX  = 16'h0053,
		CMD_FILE_DAT = 16'h0054,
		CMD_FILE_IDX = 16'h0055
	} hps_cmd_e;

	// one accepted word, with the command of its window
	typedef struct packed {
		logic      valid;
		logic      first;
		hps_cmd_e  cmd;
		hps_idx_t  idx;
		hps_word_t data;
	} hps_frame_t;

endpackage

`default_nettype wire

/* src/hps_cfg.svh */
`ifndef HPS_CFG_SVH
`define HPS_CFG_SVH

//////////////////////////////////////////////////
// host bus geometry
//////////////////////////////////////////////////

// one word on the host bus
`define HPS_WORD_W 16

// word counter inside one enable window
`define HPS_IDX_W 10

//////////////////////////////////////////////////
// core side widths
//////////////////////////////////////////////////

`define HPS_ADDR_W 25
`define HPS_JOY_W 32

// system clocks per half period of the ps/2 clock
`define PS2_DIV 4

// keyboard fifo holds 2**PS2_FIFO_BITS bytes
`define PS2_FIFO_BITS 4

`endif

/* src/hps_cmd_framer.sv */
`timescale 1ns/1ns
`default_nettype none

module hps_cmd_framer
	import hps_bus_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  hps_word_t  io_din,
	output hps_frame_t frame
);

	logic      en_q;
	logic      stb_q;
	hps_word_t din_q;
	hps_idx_t  word_cnt;
	hps_cmd_e  cmd_now;

	//////////////////////////////////////////////////
	// input stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			en_q  <= 1'b0;
			stb_q <= 1'b0;
		end else begin
			en_q  <= io_enable;
			stb_q <= io_strobe;
		end
	end

	always_ff @(posedge clk_sys) begin
		din_q <= io_din;
	end

	// word 0 carries its own code, later words reuse the latched one
	always_comb begin
		if (word_cnt == '0) begin
			cmd_now = hps_cmd_e'(din_q);
		end else begin
			cmd_now = frame.cmd;
		end
	end

	//////////////////////////////////////////////////
	// frame register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frame    <= '0;
			word_cnt <= '0;
		end else if (!en_q) begin
			// window closed, forget command and position
			frame    <= '0;
			word_cnt <= '0;
		end else begin
			frame.valid <= stb_q;
			if (stb_q) begin
				frame.first <= (word_cnt == '0);
				frame.cmd   <= cmd_now;
				frame.idx   <= word_cnt;
				frame.data  <= din_q;
				// saturate on very long argument lists
				if (word_cnt != '1) begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/hps_dev_pkg.sv */
`default_nettype none

`include "hps_cfg.svh"

package hps_dev_pkg;

	//////////////////////////////////////////////////
	// file download port
	//////////////////////////////////////////////////

	typedef logic [`HPS_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [7:0] ioctl_byte_t;

	// single byte write towards the core
	typedef struct packed {
		logic        wr;
		ioctl_addr_t addr;
		ioctl_byte_t data;
	} ioctl_wr_t;

	//////////////////////////////////////////////////
	// ps/2 keyboard
	//////////////////////////////////////////////////

	typedef logic [7:0] ps2_byte_t;

	typedef enum logic [2:0] {
		PS2_IDLE,
		PS2_START,
		PS2_DATA,
		PS2_PARITY,
		PS2_STOP
	} ps2_tx_state_e;

endpackage

`default_nettype wire

/* src/hps_file_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module hps_file_loader
	import hps_bus_pkg::*, hps_dev_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  hps_frame_t frame,
	output ioctl_wr_t  ioctl,
	output logic       ioctl_download,
	output logic [7:0] ioctl_index
);

	ioctl_addr_t addr_cnt;
	logic        arg_wr;
	logic        tx_start;

	assign arg_wr = frame.valid & ~frame.first;

	// a non-zero low byte opens the download, zero closes it
	assign tx_start = (frame.data[7:0] != 8'h00);

	//////////////////////////////////////////////////
	// download control and write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl          <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			addr_cnt       <= '0;
		end else begin
			// write strobe lasts one clock
			ioctl.wr <= 1'b0;
			if (arg_wr) begin
				case (frame.cmd)
					CMD_FILE_IDX: ioctl_index <= frame.data[7:0];
					CMD_FILE_TX: begin
						if (tx_start) begin
							addr_cnt       <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// leaves the byte count visible
							ioctl.addr     <= addr_cnt;
							ioctl_download <= 1'b0;
						end
					end
					CMD_FILE_DAT: begin
						ioctl.wr   <= 1'b1;
						ioctl.addr <= addr_cnt;
						ioctl.data <= frame.data[7:0];
						addr_cnt   <= addr_cnt + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/hps_input_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hps_cfg.svh"

module hps_input_regs
	import hps_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  hps_frame_t            frame,
	input  logic [31:0]           status_in,
	input  logic                  status_set,
	output logic [`HPS_JOY_W-1:0] joystick_0,
	output logic [`HPS_JOY_W-1:0] joystick_1,
	output logic [31:0]           status,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output hps_word_t             io_dout
);

	logic [7:0]  cfg;
	logic        set_q;
	logic [3:0]  stat_cnt;
	logic [31:0] stat_req;
	logic        arg_wr;
	logic        lo_half;
	logic        active;
	hps_word_t   rd_word;

	assign arg_wr  = frame.valid & ~frame.first;
	assign lo_half = (frame.idx == hps_idx_t'(1));

	// a window is open once word 0 has been framed
	assign active = frame.first | (frame.idx != '0);

	// cfg bits 2, 3 and 5 belong to the video side
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	//////////////////////////////////////////////////
	// host written registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (arg_wr) begin
			case (frame.cmd)
				CMD_CFG: cfg <= frame.data[7:0];
				CMD_JOY0: begin
					if (lo_half) joystick_0[`HPS_WORD_W-1:0] <= frame.data;
					else joystick_0[`HPS_JOY_W-1:`HPS_WORD_W] <= frame.data;
				end
				CMD_JOY1: begin
					if (lo_half) joystick_1[`HPS_WORD_W-1:0] <= frame.data;
					else joystick_1[`HPS_JOY_W-1:`HPS_WORD_W] <= frame.data;
				end
				CMD_STATUS: begin
					if (lo_half) status[15:0] <= frame.data;
					else status[31:16] <= frame.data;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// core status request
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			set_q    <= 1'b0;
			stat_cnt <= '0;
			stat_req <= '0;
		end else begin
			set_q <= status_set;
			if (status_set && !set_q) begin
				stat_cnt <= stat_cnt + 1'b1;
				stat_req <= status_in;
			end
		end
	end

	// read word, only the request command returns data
	always_comb begin
		rd_word = '0;
		if (frame.cmd == CMD_STAT_REQ) begin
			if (frame.first) begin
				rd_word = {8'h00, 4'hA, stat_cnt};
			end else if (lo_half) begin
				rd_word = stat_req[15:0];
			end else if (frame.idx == hps_idx_t'(2)) begin
				rd_word = stat_req[31:16];
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			io_dout <= '0;
		end else if (!active) begin
			io_dout <= '0;
		end else if (frame.valid) begin
			io_dout <= rd_word;
		end
	end

endmodule

`default_nettype wire

/* src/hps_io.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hps_cfg.svh"

module hps_io
	import hps_bus_pkg::*, hps_dev_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  io_enable,
	input  logic                  io_strobe,
	input  hps_word_t             io_din,
	output hps_word_t             io_dout,
	output logic                  io_wait,
	output logic [`HPS_JOY_W-1:0] joystick_0,
	output logic [`HPS_JOY_W-1:0] joystick_1,
	output logic [31:0]           status,
	input  logic [31:0]           status_in,
	input  logic                  status_set,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output ioctl_wr_t             ioctl,
	output logic                  ioctl_download,
	output logic [7:0]            ioctl_index,
	input  logic                  ioctl_wait,
	output logic                  ps2_kbd_clk_out,
	output logic                  ps2_kbd_data_out,
	input  logic                  ps2_kbd_clk_in,
	input  logic                  ps2_kbd_data_in
);

	hps_frame_t frame;

	// core back-pressure goes straight to the host
	assign io_wait = ioctl_wait;

	hps_cmd_framer u_framer (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.frame     (frame)
	);

	hps_input_regs u_regs (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.frame              (frame),
		.status_in          (status_in),
		.status_set         (status_set),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.io_dout            (io_dout)
	);

	hps_file_loader u_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.frame          (frame),
		.ioctl          (ioctl),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index)
	);

	ps2_kbd_tx u_kbd (
		.clk_sys          (clk_sys),
		.rst_n            (rst_n),
		.frame            (frame),
		.ps2_kbd_clk_in   (ps2_kbd_clk_in),
		.ps2_kbd_data_in  (ps2_kbd_data_in),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out)
	);

endmodule

`default_nettype wire

/* src/ps2_kbd_tx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hps_cfg.svh"

module ps2_kbd_tx
	import hps_bus_pkg::*, hps_dev_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  hps_frame_t frame,
	input  logic       ps2_kbd_clk_in,
	input  logic       ps2_kbd_data_in,
	output logic       ps2_kbd_clk_out,
	output logic       ps2_kbd_data_out
);

	localparam int DIV_W = (`PS2_DIV > 1) ? $clog2(`PS2_DIV) : 1;
	localparam int DEPTH = 1 << `PS2_FIFO_BITS;

	logic [DIV_W-1:0]        div_cnt;
	logic                    ps2_clk;
	logic                    rise_tick;
	logic                    fall_tick;
	ps2_byte_t               fifo_mem [DEPTH];
	logic [`PS2_FIFO_BITS:0] wptr;
	logic [`PS2_FIFO_BITS:0] rptr;
	logic                    fifo_empty;
	logic                    fifo_full;
	logic                    push;
	logic [1:0]              clk_sync;
	logic [1:0]              dat_sync;
	logic [1:0]              idle_cnt;
	ps2_tx_state_e           state;
	ps2_byte_t               tx_byte;
	logic [2:0]              bit_cnt;
	logic                    parity;

	//////////////////////////////////////////////////
	// clock divider
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ps2_clk <= 1'b0;
		end else if (div_cnt == DIV_W'(`PS2_DIV - 1)) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign rise_tick = (div_cnt == DIV_W'(`PS2_DIV - 1)) & ~ps2_clk;
	assign fall_tick = (div_cnt == DIV_W'(`PS2_DIV - 1)) & ps2_clk;

	//////////////////////////////////////////////////
	// byte fifo
	//////////////////////////////////////////////////

	// 0xff in the high byte marks a word with nothing to send
	assign push = frame.valid & ~frame.first & (frame.cmd == CMD_KBD) &
		(frame.data[15:8] != 8'hFF) & ~fifo_full;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[`PS2_FIFO_BITS-1:0] == rptr[`PS2_FIFO_BITS-1:0]) &&
		(wptr[`PS2_FIFO_BITS] != rptr[`PS2_FIFO_BITS]);

	always_ff @(posedge clk_sys) begin
		if (push) fifo_mem[wptr[`PS2_FIFO_BITS-1:0]] <= frame.data[7:0];
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wptr     <= '0;
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
		end else begin
			if (push) wptr <= wptr + 1'b1;
			clk_sync <= {clk_sync[0], ps2_kbd_clk_in};
			dat_sync <= {dat_sync[0], ps2_kbd_data_in};
		end
	end

	//////////////////////////////////////////////////
	// frame transmitter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state            <= PS2_IDLE;
			rptr             <= '0;
			idle_cnt         <= '0;
			tx_byte          <= '0;
			bit_cnt          <= '0;
			parity           <= 1'b1;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			if (rise_tick) begin
				ps2_kbd_clk_out <= 1'b1;
				case (state)
					PS2_IDLE: begin
						// host inhibits by pulling clock or data low
						if (!(clk_sync[1] && dat_sync[1])) begin
							idle_cnt <= '0;
						end else if (idle_cnt != 2'd3) begin
							idle_cnt <= idle_cnt + 1'b1;
						end else if (!fifo_empty) begin
							tx_byte          <= fifo_mem[rptr[`PS2_FIFO_BITS-1:0]];
							rptr             <= rptr + 1'b1;
							idle_cnt         <= '0;
							parity           <= 1'b1;
							ps2_kbd_data_out <= 1'b0;
							state            <= PS2_START;
						end
					end
					PS2_START: begin
						ps2_kbd_data_out <= tx_byte[0];
						parity           <= parity ^ tx_byte[0];
						tx_byte          <= tx_byte >> 1;
						bit_cnt          <= '0;
						state            <= PS2_DATA;
					end
					PS2_DATA: begin
						if (bit_cnt == 3'd7) begin
							ps2_kbd_data_out <= parity;
							state            <= PS2_PARITY;
						end else begin
							ps2_kbd_data_out <= tx_byte[0];
							parity           <= parity ^ tx_byte[0];
							tx_byte          <= tx_byte >> 1;
							bit_cnt          <= bit_cnt + 1'b1;
						end
					end
					PS2_PARITY: begin
						ps2_kbd_data_out <= 1'b1;
						state            <= PS2_STOP;
					end
					default: state <= PS2_IDLE;
				endcase
			end else if (fall_tick) begin
				// host samples data on the falling clock
				ps2_kbd_clk_out <= (state == PS2_IDLE);
			end
		end
	end

endmodule

`default_nettype wire

/* verif/hps_io_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module hps_io_checker
	import hps_bus_pkg::*, hps_dev_pkg::*;
(
	input logic          clk_sys,
	input logic          rst_n,
	input logic          io_enable,
	input hps_word_t     io_dout,
	input ioctl_wr_t     ioctl,
	input logic          ps2_kbd_clk_out,
	input ps2_tx_state_e kbd_state
);

	// one byte per write strobe
	wr_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl.wr |=> !ioctl.wr)
		else $error("ioctl.wr stayed high for more than one cycle");

	// read word drains two clocks behind the framer
	dout_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!io_enable && !$past(io_enable) && !$past(io_enable, 2) && !$past(io_enable, 3))
		|-> (io_dout == '0))
		else $error("io_dout not zero with the enable window closed");

	kbd_clk_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(kbd_state == PS2_IDLE) |-> ps2_kbd_clk_out)
		else $error("ps2 clock low with no frame in progress");

endmodule

bind hps_io hps_io_checker u_checker (
	.clk_sys         (clk_sys),
	.rst_n           (rst_n),
	.io_enable       (io_enable),
	.io_dout         (io_dout),
	.ioctl           (ioctl),
	.ps2_kbd_clk_out (ps2_kbd_clk_out),
	.kbd_state       (u_kbd.state)
);

`default_nettype wire

/* verif/hps_io_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hps_cfg.svh"

module hps_io_tb
	import hps_bus_pkg::*, hps_dev_pkg::*;
();

	typedef enum logic [3:0] {
		K_JOY0, K_JOY1, K_STATUS, K_CFG, K_STATREQ, K_INDEX,
		K_DL_ON, K_DL_DATA, K_DL_OFF, K_KBD, K_KBD_HOLD
	} kind_e;

	// one host command and what it should leave behind
	typedef struct packed {
		hps_cmd_e        cmd;
		logic [2:0]      nargs;
		hps_word_t [3:0] args;
		kind_e           kind;
		logic [47:0]     exp;
	} row_t;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  io_enable;
	logic                  io_strobe;
	hps_word_t             io_din;
	hps_word_t             io_dout;
	logic                  io_wait;
	logic [`HPS_JOY_W-1:0] joystick_0;
	logic [`HPS_JOY_W-1:0] joystick_1;
	logic [31:0]           status;
	logic [31:0]           status_in;
	logic                  status_set;
	logic [1:0]            buttons;
	logic                  forced_scandoubler;
	ioctl_wr_t             ioctl;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	logic                  ioctl_wait;
	logic                  ps2_kbd_clk_out;
	logic                  ps2_kbd_data_out;
	logic                  ps2_kbd_clk_in;
	logic                  ps2_kbd_data_in;

	row_t        rows [$];
	string       names [$];
	logic [31:0] stat_vals [2];
	hps_word_t   rd_words [5];
	ioctl_wr_t   wr_q [$];
	logic [10:0] ps2_q [$];
	logic [10:0] cap_bits;
	int          cap_cnt;
	int          fall_cnt;

	hps_io u_dut (.*);

	always #2 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// monitors
	//////////////////////////////////////////////////

	// wr is high for one whole clock, so one falling edge sees it
	always @(negedge clk_sys) begin
		if (rst_n && ioctl.wr) begin
			wr_q.push_back(ioctl);
		end
	end

	// bit 0 of a captured frame is the first bit on the line
	always @(negedge ps2_kbd_clk_out) begin
		if (rst_n) begin
			fall_cnt++;
			cap_bits = {ps2_kbd_data_out, cap_bits[10:1]};
			cap_cnt++;
			if (cap_cnt == 11) begin
				ps2_q.push_back(cap_bits);
				cap_cnt = 0;
			end
		end
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input hps_word_t exp, input hps_word_t act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_joy(input string name, input logic [`HPS_JOY_W-1:0] exp,
		input logic [`HPS_JOY_W-1:0] act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_ioctl(input string name, input ioctl_wr_t exp, input ioctl_wr_t act);
		string exp_txt;
		string act_txt;
		if (act !== exp) begin
			exp_txt = $sformatf("wr %b addr %h data %h", exp.wr, exp.addr, exp.data);
			act_txt = $sformatf("wr %b addr %h data %h", act.wr, act.addr, act.data);
			fail_now($sformatf("CHECK FAILED %s expected %s actual %s", name, exp_txt, act_txt));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_ps2(input string name, input logic [10:0] exp, input logic [10:0] act);
		if (act !== exp) begin
			fail_now($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
		end
	endtask

	// start 0, data lsb first, odd parity, stop 1
	function automatic logic [10:0] ps2_frame(input ps2_byte_t b);
		return {1'b1, ~(^b), b, 1'b0};
	endfunction

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////

	task automatic add_row(input string name, input hps_cmd_e cmd, input int nargs,
		input logic [63:0] args, input kind_e kind, input logic [47:0] exp);
		row_t r;
		r.cmd   = cmd;
		r.nargs = 3'(nargs);
		r.args  = args;
		r.kind  = kind;
		r.exp   = exp;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_table();
		hps_word_t   w [6];
		ioctl_byte_t b [5];
		ps2_byte_t   k [5];
		logic [7:0]  c;
		for (int i = 0; i < 6; i++) begin
			w[i] = hps_word_t'($urandom);
		end
		for (int i = 0; i < 5; i++) begin
			b[i] = ioctl_byte_t'($urandom);
			k[i] = ps2_byte_t'($urandom);
		end
		c            = 8'($urandom);
		stat_vals[0] = $urandom;
		stat_vals[1] = $urandom;
		add_row("joy0", CMD_JOY0, 2, {32'h0, w[1], w[0]}, K_JOY0, {16'h0, w[1], w[0]});
		add_row("joy1", CMD_JOY1, 2, {32'h0, w[3], w[2]}, K_JOY1, {16'h0, w[3], w[2]});
		add_row("status", CMD_STATUS, 2, {32'h0, w[5], w[4]}, K_STATUS, {16'h0, w[5], w[4]});
		add_row("cfg", CMD_CFG, 1, {56'h0, c}, K_CFG, {45'h0, c[4], c[1:0]});
		add_row("stat_req", CMD_STAT_REQ, 2, 64'h0, K_STATREQ, {16'h0, stat_vals[1]});
		add_row("file_idx", CMD_FILE_IDX, 1, 64'h7, K_INDEX, 48'h7);
		add_row("file_start", CMD_FILE_TX, 1, 64'h1, K_DL_ON, 48'h0);
		add_row("file_data_a", CMD_FILE_DAT, 4,
			{8'h00, b[3], 8'h00, b[2], 8'h00, b[1], 8'h00, b[0]}, K_DL_DATA, 48'd0);
		add_row("file_data_b", CMD_FILE_DAT, 1, {56'h0, b[4]}, K_DL_DATA, 48'd4);
		add_row("file_stop", CMD_FILE_TX, 1, 64'h0, K_DL_OFF, {14'h0, 1'b0, 25'd5, b[4]});
		// second word is marked empty and must not reach the line
		add_row("kbd", CMD_KBD, 4,
			{8'h00, k[2], 8'h00, k[1], 8'hFF, k[3], 8'h00, k[0]}, K_KBD, 48'h0);
		add_row("kbd_hold", CMD_KBD, 1, {56'h0, k[4]}, K_KBD_HOLD, 48'h0);
	endtask

	//////////////////////////////////////////////////
	// host bus and core side tasks
	//////////////////////////////////////////////////

	// one strobe every third clock with each read word sampled two clocks later
	task automatic host_cmd(input row_t r);
		hps_word_t words [5];
		int        t;
		words[0] = r.cmd;
		for (int i = 0; i < 4; i++) begin
			words[i + 1] = r.args[i];
		end
		@(negedge clk_sys);
		io_enable = 1'b1;
		for (int i = 0; i <= r.nargs; i++) begin
			t = 0;
			while (io_wait) begin
				@(negedge clk_sys);
				t++;
				if (t > 100) fail_now("io_wait stayed high during a command");
			end
			io_strobe = 1'b1;
			io_din    = words[i];
			@(negedge clk_sys);
			io_strobe = 1'b0;
			@(negedge clk_sys);
			@(negedge clk_sys);
			rd_words[i] = io_dout;
		end
		io_enable = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pulse_status(input logic [31:0] v);
		@(negedge clk_sys);
		status_in  = v;
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic wait_frames(input int count, input string name);
		int t;
		t = 0;
		while (ps2_q.size() < count) begin
			@(negedge clk_sys);
			t++;
			if (t > 400 * count) fail_now($sformatf("no ps/2 frame arrived in %s", name));
		end
	endtask

	task automatic check_kbd(input int i);
		row_t r;
		int   n;
		r = rows[i];
		n = 0;
		for (int a = 0; a < r.nargs; a++) begin
			if (r.args[a][15:8] != 8'hFF) n++;
		end
		wait_frames(n, names[i]);
		for (int a = 0; a < r.nargs; a++) begin
			if (r.args[a][15:8] != 8'hFF) begin
				check_ps2(names[i], ps2_frame(r.args[a][7:0]), ps2_q.pop_front());
			end
		end
		repeat (300) @(negedge clk_sys);
		if (ps2_q.size() != 0) fail_now({"extra ps/2 frame sent after ", names[i]});
	endtask

	task automatic check_row(input int i);
		row_t  r;
		string n;
		r = rows[i];
		n = names[i];
		case (r.kind)
			K_JOY0: check_joy(n, r.exp[31:0], joystick_0);
			K_JOY1: check_joy(n, r.exp[31:0], joystick_1);
			K_STATUS: check_joy(n, r.exp[31:0], status);
			K_CFG: check_word(n, r.exp[15:0], {13'h0, forced_scandoubler, buttons});
			K_STATREQ: begin
				// header is 0xa0 plus the two requests seen so far
				check_word({n, " header"}, 16'h00A0 + 16'd2, rd_words[0]);
				check_word({n, " low"}, r.exp[15:0], rd_words[1]);
				check_word({n, " high"}, r.exp[31:16], rd_words[2]);
				// read word drops back to zero once the window has closed
				repeat (3) @(negedge clk_sys);
				check_word({n, " closed"}, '0, io_dout);
			end
			K_INDEX: check_word(n, r.exp[15:0], {8'h00, ioctl_index});
			K_DL_ON: check_bit(n, 1'b1, ioctl_download);
			K_DL_DATA: begin
				check_bit(n, 1'b1, ioctl_download);
				if (wr_q.size() != r.nargs) fail_now({"wrong number of writes in ", n});
				for (int a = 0; a < r.nargs; a++) begin
					check_ioctl(n, {1'b1, ioctl_addr_t'(r.exp) + ioctl_addr_t'(a),
						r.args[a][7:0]}, wr_q.pop_front());
				end
			end
			K_DL_OFF: begin
				check_bit(n, 1'b0, ioctl_download);
				check_ioctl(n, ioctl_wr_t'(r.exp[33:0]), ioctl);
			end
			default: check_kbd(i);
		endcase
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int falls;
		clk_sys         = 1'b0;
		rst_n           = 1'b0;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		status_in       = '0;
		status_set      = 1'b0;
		ioctl_wait      = 1'b0;
		ps2_kbd_clk_in  = 1'b1;
		ps2_kbd_data_in = 1'b1;
		cap_bits        = '0;
		cap_cnt         = 0;
		fall_cnt        = 0;
		void'($urandom(37766));
		build_table();
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_word("reset io_dout", '0, io_dout);
		check_joy("reset joystick_0", '0, joystick_0);
		check_joy("reset joystick_1", '0, joystick_1);
		check_joy("reset status", '0, status);
		check_word("reset cfg", '0, {13'h0, forced_scandoubler, buttons});
		check_ioctl("reset ioctl", '0, ioctl);
		check_bit("reset ioctl_download", 1'b0, ioctl_download);
		check_bit("reset ps2 clk", 1'b1, ps2_kbd_clk_out);
		check_bit("reset ps2 data", 1'b1, ps2_kbd_data_out);
		foreach (rows[i]) begin
			if (rows[i].kind == K_STATREQ) begin
				pulse_status(stat_vals[0]);
				pulse_status(stat_vals[1]);
			end
			// host inhibits the keyboard before the byte is queued
			if (rows[i].kind == K_KBD_HOLD) begin
				ps2_kbd_clk_in = 1'b0;
				repeat (4) @(negedge clk_sys);
			end
			falls = fall_cnt;
			host_cmd(rows[i]);
			if (rows[i].kind == K_KBD_HOLD) begin
				repeat (300) @(negedge clk_sys);
				if (fall_cnt != falls) fail_now("ps/2 clock fell while the host held it low");
				ps2_kbd_clk_in = 1'b1;
			end
			check_row(i);
		end
		for (int i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			ioctl_wait = 1'($urandom_range(0, 1));
			#1;
			check_bit("io_wait", ioctl_wait, io_wait);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
